/* fpc_rr_mux.f */
logic/fpc_map_pkg.sv
logic/fpc_types_pkg.sv
logic/block_ram.sv
logic/fpc_rr_sequencer.sv
logic/fpc_addr_capture.sv
logic/fpc_rr_mux.sv
tb/fpc_rr_mux_sva.sv
tb/fpc_rr_mux_tb.sv

/* Bender.yml */
package:
  name: fpc_rr_mux

sources:
  # packages first, the rtl imports them
  - logic/fpc_map_pkg.sv
  - logic/fpc_types_pkg.sv
  - logic/block_ram.sv
  - logic/fpc_rr_sequencer.sv
  - logic/fpc_addr_capture.sv
  - logic/fpc_rr_mux.sv

  - target: simulation
    files:
      - tb/fpc_rr_mux_sva.sv
      - tb/fpc_rr_mux_tb.sv

/* tb/fpc_rr_mux_tb.sv */
module fpc_rr_mux_tb
   import fpc_map_pkg::*;
   import fpc_types_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] seed = 32'hcf45_05ea;
   localparam int requests_per_channel = 50;          // 200 requests over all channels
   localparam int wait_limit = 1000;                  // cycles before a wait gives up

   logic                    clock;
   logic                    reset;
   logic                    pio_wvalid;
   logic [63:0]             pio_wdata;
   pio_addr_t               pio_addr;
   logic [num_channels-1:0] rr_valid;
   logic [num_channels-1:0] rr_ready;
   vaddr_t                  req_addr [num_channels];  // per channel request address
   logic                    rrm_valid;
   paddr_t                  rrm_addr;
   tag_t                    rrm_tag;
   logic                    rrm_ready;
   logic                    traffic_on;               // keeps the ready driver running
   int unsigned             timeouts;
   int unsigned             mismatches;
   int unsigned             issued [num_channels];
   int unsigned             accepted [num_channels];  // output transfers per tag channel

   fpc_rr_mux fpc_rr_mux_i
   (
      .*,
      .rr0_addr (req_addr[0]),
      .rr1_addr (req_addr[1]),
      .rr2_addr (req_addr[2]),
      .rr3_addr (req_addr[3])
   );

   bind fpc_rr_mux fpc_rr_mux_sva sva_i (.*);

   initial clock = 1'b0;
   always #50 clock = ~clock;                         // 100 ns period

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [63:0] rand64(inout logic [31:0] state);
      logic [31:0] hi;
      state = lcg_next(state);
      hi    = state;
      state = lcg_next(state);
      return {hi, state};
   endfunction

   task automatic pio_write(input pio_addr_t addr, input logic [63:0] data);
      @(posedge clock);
      #1;
      pio_wvalid = 1'b1;                              // one cycle strobe
      pio_addr   = addr;
      pio_wdata  = data;
      @(posedge clock);
      #1;
      pio_wvalid = 1'b0;
   endtask

   task automatic fill_page_table(inout logic [31:0] state);
      logic [63:0] data;
      for (int i = 0; i < 2**pt_depth_bits; i++)
      begin
         data = rand64(state);
         pio_write(pio_addr_t'({2'd1, data[8:7], 7'(i)}), data); // bits 8..7 unused
      end
   endtask

   // writes to regions 0, 2 and 3 that must not reach the table
   task automatic write_decoys(inout logic [31:0] state, input int count);
      logic [63:0] data;
      logic [1:0]  region;
      for (int i = 0; i < count; i++)
      begin
         data   = rand64(state);
         region = data[31:30];
         if (region == 2'd1)
         begin
            region = 2'd3;
         end
         pio_write(pio_addr_t'({region, data[8:7], 7'(i)}), ~data); // word i of another region
      end
   endtask

   task automatic drive_channel(input int ch);
      logic [31:0] state;
      int          waited;
      state = seed + 32'(ch + 1) * 32'h9e37_79b9;     // own stream per channel
      for (int n = 0; n < requests_per_channel; n++)
      begin
         state = lcg_next(state);
         repeat (state[31:30])
         begin
            @(posedge clock);                         // idle gap of 0 to 3 cycles
            #1;
         end
         req_addr[ch] = rand64(state);
         rr_valid[ch] = 1'b1;
         issued[ch]++;
         waited = 0;
         do
         begin
            @(negedge clock);
            waited++;
         end
         while (!rr_ready[ch] && waited < wait_limit);
         if (!rr_ready[ch])
         begin
            timeouts++;
            $display("channel %0d saw no rr_ready within %0d cycles", ch, wait_limit);
            @(posedge clock);
            #1;
            rr_valid[ch] = 1'b0;
            return;
         end
         @(posedge clock);                            // transfer at this edge
         #1;
         rr_valid[ch] = 1'b0;
      end
   endtask

   task automatic drive_ready();
      logic [31:0] state;
      state = seed ^ 32'h5a5a_a5a5;
      while (traffic_on)
      begin
         state     = lcg_next(state);
         rrm_ready = (state[31:30] != 2'd0);          // stall about one cycle in four
         @(posedge clock);
         #1;
      end
      rrm_ready = 1'b1;
   endtask

   // count transfers on the output side by the channel in the tag
   always @(negedge clock)
   begin
      if (rrm_valid === 1'b1 && rrm_ready === 1'b1)
      begin
         accepted[rrm_tag[4:3]]++;
      end
   end

   initial
   begin
      logic [31:0] state;
      state      = seed;
      reset      = 1'b1;
      pio_wvalid = 1'b0;
      pio_wdata  = '0;
      pio_addr   = '0;
      rr_valid   = '0;
      rrm_ready  = 1'b0;
      traffic_on = 1'b0;
      timeouts   = 0;
      mismatches = 0;
      for (int c = 0; c < num_channels; c++)
      begin
         req_addr[c] = '0;
         issued[c]   = 0;
         accepted[c] = 0;
      end
      repeat (5) @(posedge clock);
      #1;
      reset = 1'b0;
      fill_page_table(state);
      write_decoys(state, 2**pt_depth_bits);           // every table word again in another region
      traffic_on = 1'b1;
      fork
         drive_ready();
         begin
            fork
               drive_channel(0);
               drive_channel(1);
               drive_channel(2);
               drive_channel(3);
               write_decoys(state, 40);
            join
            traffic_on = 1'b0;
         end
      join
      for (int c = 0; c < num_channels; c++)
      begin
         if (issued[c] != accepted[c])
         begin
            mismatches++;
            $display("CHECK FAILED accepted[%0d] %h expected %h", c, accepted[c], issued[c]);
         end
      end
      $display("timeouts %0d, count mismatches %0d, assertion errors %0d",
               timeouts, mismatches, fpc_rr_mux_i.sva_i.error_count);
      if (timeouts == 0 && mismatches == 0 && fpc_rr_mux_i.sva_i.error_count == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* tb/fpc_rr_mux_sva.sv */
module fpc_rr_mux_sva
   import fpc_map_pkg::*;
   import fpc_types_pkg::*;
(
   input logic                    clock,
   input logic                    reset,
   input logic                    pio_wvalid,
   input logic [63:0]             pio_wdata,
   input pio_addr_t               pio_addr,
   input logic [num_channels-1:0] rr_valid,
   input logic [num_channels-1:0] rr_ready,
   input vaddr_t                  rr0_addr,
   input vaddr_t                  rr1_addr,
   input vaddr_t                  rr2_addr,
   input vaddr_t                  rr3_addr,
   input logic                    rrm_valid,
   input paddr_t                  rrm_addr,
   input tag_t                    rrm_tag,
   input logic                    rrm_ready,
   input channel_t                channel,  // sequencer pointer inside the dut
   input phase_t                  phase     // sequencer phase inside the dut
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned             error_count = 0;            // read by the testbench at the end
   pt_entry_t               shadow [2**pt_depth_bits];  // table as software wrote it
   vaddr_t                  held_addr;                  // request of the served channel
   paddr_t                  exp_addr;
   tag_t                    exp_tag;
   logic                    handshake;
   logic                    sel_hit;                    // select cycle that finds a request
   logic [num_channels-1:0] held_q;                     // valid in every cycle since last handshake
   channel_t                last_ch;                    // channel of the last handshake

   // true when a channel between from_ch and to_ch was waiting all along
   function automatic logic passed_over(logic [num_channels-1:0] held, channel_t from_ch,
                                        channel_t to_ch);
      channel_t k;
      logic     hit;
      logic     reached;
      hit     = 1'b0;
      reached = 1'b0;
      for (int j = 1; j < num_channels; j++)
      begin
         k = channel_t'(from_ch + j);
         if (k == to_ch)
         begin
            reached = 1'b1;
         end
         if (!reached && held[k])
         begin
            hit = 1'b1;                                 // skipped a held request
         end
      end
      return hit;
   endfunction

   task automatic log_failure(input string msg);
      $error("%s", msg);
      error_count++;
   endtask

   // shadow table, region 1 only, word index in pio bits 6..0
   always_ff @(posedge clock)
   begin
      if (pio_wvalid && pio_addr[10:9] == 2'd1)
      begin
         shadow[pio_addr[6:0]] <= pio_wdata[63:21];
      end
   end

   always_comb
   begin
      case (channel)
         2'd0:    held_addr = rr0_addr;
         2'd1:    held_addr = rr1_addr;
         2'd2:    held_addr = rr2_addr;
         default: held_addr = rr3_addr;
      endcase
      exp_addr  = {shadow[{channel, held_addr[25:21]}], held_addr[20:9], 9'd0};
      exp_tag   = tag_t'(channel) * 8 + tag_t'(held_addr[11:9]);
      handshake = rrm_valid && rrm_ready;
      sel_hit   = (phase == phase_select) && rr_valid[channel];
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         held_q  <= '1;
         last_ch <= channel_t'(num_channels - 1);     // walk starts at channel 0
      end
      else if (handshake)
      begin
         held_q  <= '1;                               // new window opens
         last_ch <= channel;
      end
      else
      begin
         held_q <= held_q & rr_valid;
      end
   end

   a_reset: assert property (@(posedge clock) reset |=> !rrm_valid && rr_ready == '0)
      else log_failure($sformatf("CHECK FAILED rrm_valid %h rr_ready %h after reset",
                                 $sampled(rrm_valid), $sampled(rr_ready)));

   a_ready: assert property (@(posedge clock) disable iff (reset)
      rr_ready != '0 |-> rrm_valid && rrm_ready)
      else log_failure($sformatf("CHECK FAILED rr_ready %h without an output transfer",
                                 $sampled(rr_ready)));

   a_hold: assert property (@(posedge clock) disable iff (reset)
      rrm_valid && !rrm_ready |=> rrm_valid && $stable(rrm_addr) && $stable(rrm_tag))
      else log_failure("output request changed while the output was stalled");

   a_addr: assert property (@(posedge clock) disable iff (reset)
      rrm_valid |-> rrm_addr == exp_addr)
      else log_failure($sformatf("CHECK FAILED rrm_addr %h expected %h",
                                 $sampled(rrm_addr), $sampled(exp_addr)));

   a_tag: assert property (@(posedge clock) disable iff (reset)
      rrm_valid |-> rrm_tag == exp_tag)
      else log_failure($sformatf("CHECK FAILED rrm_tag %h expected %h",
                                 $sampled(rrm_tag), $sampled(exp_tag)));

   a_onehot: assert property (@(posedge clock) disable iff (reset)
      handshake |-> rr_ready == (4'b0001 << rrm_tag[4:3]))
      else log_failure($sformatf("CHECK FAILED rr_ready %h expected %h", $sampled(rr_ready),
                                 4'b0001 << $sampled(rrm_tag[4:3])));

   a_order: assert property (@(posedge clock) disable iff (reset)
      handshake |-> !passed_over(held_q & rr_valid, last_ch, channel))
      else log_failure($sformatf("round-robin order broken, channel %0d served after %0d",
                                 $sampled(channel), $sampled(last_ch)));

   a_latency: assert property (@(posedge clock) disable iff (reset)
      sel_hit |-> !rrm_valid [*3] ##1 rrm_valid)
      else log_failure("rrm_valid did not rise 3 cycles after a select on a valid channel");

   a_latency_rev: assert property (@(posedge clock) disable iff (reset)
      $rose(rrm_valid) |-> $past(sel_hit, 3))
      else log_failure("rrm_valid rose without a select on a valid channel 3 cycles before");

endmodule

/* logic/fpc_rr_mux.sv */
module fpc_rr_mux
   import fpc_map_pkg::*;
   import fpc_types_pkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   // pio write, page table region only
   input  logic                    pio_wvalid,
   input  logic [63:0]             pio_wdata,
   input  pio_addr_t               pio_addr,
   // read requests in
   input  logic [num_channels-1:0] rr_valid,
   output logic [num_channels-1:0] rr_ready,
   input  vaddr_t                  rr0_addr,
   input  vaddr_t                  rr1_addr,
   input  vaddr_t                  rr2_addr,
   input  vaddr_t                  rr3_addr,
   // multiplexed request out
   output logic                    rrm_valid,
   output paddr_t                  rrm_addr,
   output tag_t                    rrm_tag,
   input  logic                    rrm_ready
);

   channel_t  channel;                      // served channel
   phase_t    phase;                        // lookup step
   pt_index_t pt_index;                     // table read address
   pt_entry_t pt_entry;                     // table read data
   logic      pt_wvalid;                    // pio write aimed at the table

   // region decode, writes to other regions are dropped here
   assign pt_wvalid = pio_wvalid
                      && (pio_addr[pio_region_msb:pio_region_lsb] == pio_region_pt);

   fpc_rr_sequencer sequencer_i
   (
      .clock     (clock),
      .reset     (reset),
      .rr_valid  (rr_valid),
      .rrm_ready (rrm_ready),
      .channel   (channel),
      .phase     (phase),
      .rrm_valid (rrm_valid),
      .rr_ready  (rr_ready)
   );

   fpc_addr_capture capture_i
   (
      .clock    (clock),
      .rr0_addr (rr0_addr),
      .rr1_addr (rr1_addr),
      .rr2_addr (rr2_addr),
      .rr3_addr (rr3_addr),
      .channel  (channel),
      .phase    (phase),
      .pt_index (pt_index),
      .pt_entry (pt_entry),
      .rrm_addr (rrm_addr),
      .rrm_tag  (rrm_tag)
   );

   // page table, 4 channels x 32 pages of 2 MiB
   block_ram
   #(
      .data_bits (pt_width),
      .addr_bits (pt_depth_bits)
   )
   page_table_i
   (
      .clock   (clock),
      .w_valid (pt_wvalid),
      .w_addr  (pio_addr[pt_depth_bits-1:0]), // entry number within the region
      .w_data  (pio_wdata[63:page_lsb]),      // page base, low bits ignored
      .r_addr  (pt_index),
      .r_data  (pt_entry)
   );

endmodule

/* logic/fpc_addr_capture.sv */
module fpc_addr_capture
   import fpc_map_pkg::*;
   import fpc_types_pkg::*;
(
   input  logic      clock,
   input  vaddr_t    rr0_addr,
   input  vaddr_t    rr1_addr,
   input  vaddr_t    rr2_addr,
   input  vaddr_t    rr3_addr,
   input  channel_t  channel,               // from the sequencer
   input  phase_t    phase,                 // from the sequencer
   output pt_index_t pt_index,              // to the ram read address
   input  pt_entry_t pt_entry,              // ram read data
   output paddr_t    rrm_addr,
   output tag_t      rrm_tag
);

   vaddr_t     sel_addr;                    // address of the channel under select
   line_addr_t line_addr;                   // held line within the page
   pt_entry_t  entry_q;                     // held page base for the offer

   // channel address mux
   always_comb
   begin
      case (channel)
         2'd0:    sel_addr = rr0_addr;
         2'd1:    sel_addr = rr1_addr;
         2'd2:    sel_addr = rr2_addr;
         default: sel_addr = rr3_addr;
      endcase
   end

   // capture on every select cycle, the sequencer only leaves select
   // when the channel is valid so the last capture is the one that counts
   always_ff @(posedge clock)
   begin
      if (phase == phase_select)
      begin
         pt_index  <= {channel, sel_addr[page_msb:page_lsb]}; // channel part of the table
         line_addr <= sel_addr[page_lsb-1:line_bits];          // bits 20..9
      end
      if (phase == phase_lookup)
      begin
         entry_q <= pt_entry;               // keeps the offer stable under pio writes
      end
   end

   // translated request
   assign rrm_addr = {entry_q, line_addr, {line_bits{1'b0}}}; // page base, line, zeros
   assign rrm_tag  = tag_t'({channel, line_addr[2:0]});       // channel * 8 + low line bits

endmodule

/* logic/fpc_rr_sequencer.sv */
module fpc_rr_sequencer
   import fpc_map_pkg::*;
   import fpc_types_pkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic [num_channels-1:0] rr_valid,  // request level per channel
   input  logic                    rrm_ready, // output side accepts
   output channel_t                channel,   // channel being served
   output phase_t                  phase,     // lookup step for that channel
   output logic                    rrm_valid, // request offered on the output
   output logic [num_channels-1:0] rr_ready   // one-hot acknowledge to the channels
);

   logic handshake;                           // output transfer this cycle

   assign rrm_valid = (phase == phase_offer); // offer phase is the only valid cycle
   assign handshake = rrm_valid && rrm_ready;

   // channel pointer and phase
   // idle channels cost one select cycle each, a busy channel walks
   // index -> lookup -> offer and stays in offer until the handshake
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         phase   <= phase_select;
         channel <= '0;                       // start the walk at channel 0
      end
      else
      begin
         case (phase)
            phase_select:
            begin
               if (rr_valid[channel])
               begin
                  phase <= phase_index;       // address captured at this edge
               end
               else
               begin
                  channel <= channel_t'(channel + 1'b1); // skip idle channel
               end
            end
            phase_index:
            begin
               phase <= phase_lookup;         // ram reads the registered index
            end
            phase_lookup:
            begin
               phase <= phase_offer;          // entry out of the ram now
            end
            phase_offer:
            begin
               if (rrm_ready)
               begin
                  phase   <= phase_select;
                  channel <= channel_t'(channel + 1'b1); // next in cyclic order
               end
            end
            default:
            begin
               phase <= phase_select;
            end
         endcase
      end
   end

   // ready back to the channel being served
   // the channel and the output complete in the same cycle
   always_comb
   begin
      rr_ready          = '0;
      rr_ready[channel] = handshake;          // zero under back-pressure
   end

endmodule

/* logic/block_ram.sv */
module block_ram
#(
   parameter int data_bits = 43,            // word width
   parameter int addr_bits = 7              // depth is 2**addr_bits
)
(
   input  logic                 clock,
   input  logic                 w_valid,    // write strobe
   input  logic [addr_bits-1:0] w_addr,
   input  logic [data_bits-1:0] w_data,
   input  logic [addr_bits-1:0] r_addr,     // sampled every clock
   output logic [data_bits-1:0] r_data      // one cycle after r_addr
);

   logic [data_bits-1:0] mem [2**addr_bits]; // plain array, maps onto a block ram

   // write port
   always_ff @(posedge clock)
   begin
      if (w_valid)
      begin
         mem[w_addr] <= w_data;             // no byte enables, whole word
      end
   end

   // read port, registered
   // a write and a read of the same word in one cycle return the old word
   always_ff @(posedge clock)
   begin
      r_data <= mem[r_addr];                // continuous read, no enable
   end

endmodule

/* logic/fpc_types_pkg.sv */
package fpc_types_pkg;

   import fpc_map_pkg::*;

   typedef logic [$clog2(num_channels)-1:0] channel_t;  // channel number
   typedef logic [63:0]                     vaddr_t;    // request address from a channel
   typedef logic [63:0]                     paddr_t;    // translated address to the output
   typedef logic [pt_depth_bits-1:0]        pt_index_t; // {channel, page number}
   typedef logic [pt_width-1:0]             pt_entry_t; // physical page base
   typedef logic [page_lsb-line_bits-1:0]   line_addr_t; // line within a page, vaddr 20..9
   typedef logic [pio_region_msb:0]         pio_addr_t; // pio word address
   typedef logic [7:0]                      tag_t;      // {channel, low line bits}

   // sequencer walk, one pass per channel
   //   select : look at rr_valid of the current channel
   //   index  : registered table index sits on the ram read port
   //   lookup : ram output valid
   //   offer  : request on the output until accepted
   typedef enum logic [1:0]
   {
      phase_select,
      phase_index,
      phase_lookup,
      phase_offer
   } phase_t;

endpackage

/* logic/fpc_map_pkg.sv */
package fpc_map_pkg;

   // request side
   localparam int num_channels = 4;        // dma read channels feeding the mux

   // read requests cover whole 512-byte lines
   localparam int line_bits = 9;           // low output address bits, always zero

   // 2 MiB pages, each channel owns 32 of them in the table
   localparam int page_lsb = 21;           // lowest virtual bit of the page number
   localparam int page_msb = 25;           // highest translated bit, anything above is ignored

   // page table geometry
   localparam int pt_depth_bits = 7;       // 2 channel bits above 5 page bits
   localparam int pt_width = 43;           // physical page base, address bits 63..21

   // pio address decode
   // address bits 10..9 pick one of four 512-entry regions, only region 1
   // is wired up here; the other regions belong to blocks outside this mux
   localparam int pio_region_lsb = 9;      // bottom of the region select field
   localparam int pio_region_msb = 10;     // top of the region select field
   localparam logic [pio_region_msb-pio_region_lsb:0] pio_region_pt = 2'd1; // page table

endpackage
